// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

   localparam int XLEN = 32;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // instruction encodings
   typedef enum logic [6:0] {
      LUI    = 7'b0110111,
      JAL    = 7'b1101111,
      BRANCH = 7'b1100011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      OP_IMM = 7'b0010011,
      OP     = 7'b0110011
   } opcode_e;

   localparam int RD_LSB     = 7;
   localparam int F3_LSB     = 12;
   localparam int RS1_LSB    = 15;
   localparam int RS2_LSB    = 20;
   localparam int F7_SUB_BIT = 30;  // selects sub over add in OP.

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;
   localparam logic [2:0] F3_BLT     = 3'b100;
   localparam logic [2:0] F3_BLTU    = 3'b110;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // datapath control
   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
   } alu_op_e;

   typedef enum logic [1:0] {
      RD_ALU, RD_PC4, RD_IMM, RD_MEM
   } rd_src_e;

   typedef struct packed {
      logic [4:0] cnt;     // bit position.
      logic       en;      // serial datapath active.
      logic       init;    // first bit of a pass.
      logic       last;    // last bit of a pass.
      alu_op_e    alu_op;
      logic       b_imm;   // operand b from the immediate.
      rd_src_e    rd_src;
      logic       rd_we;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic       imm;     // immediate bit at cnt.
   } dp_ctrl_t;

endpackage

// File: src/rv_bus_pkg.sv
package rv_bus_pkg;

   // instruction bus, read only.
   typedef struct packed {
      logic [31:0] adr;
      logic        cyc;
   } ibus_req_t;

   typedef struct packed {
      logic [31:0] rdt;
      logic        ack;
   } ibus_rsp_t;

   // data bus, aligned words only.
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        we;
      logic        cyc;
   } dbus_req_t;

   typedef struct packed {
      logic [31:0] rdt;
      logic        ack;
   } dbus_rsp_t;

endpackage

// File: src/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_isa_pkg::*; (
   input  logic              clk,
   input  logic              i_arst_n,
   input  logic              i_ibus_ack,
   input  logic [XLEN-1:0]   i_ibus_rdt,
   input  logic              i_dbus_ack,
   input  logic              i_eq,
   input  logic              i_lt,
   output dp_ctrl_t          o_ctrl,
   output logic              o_fetch,
   output logic              o_mem_req,
   output logic              o_mem_we,
   output logic              o_pc_load,
   output logic              o_take
);

   typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB} state_e;

   state_e          state;
   state_e          state_nxt;
   logic [4:0]      cnt;
   logic            pass2;
   logic [XLEN-1:0] ir;
   logic [XLEN-1:0] imm_sr;
   logic [XLEN-1:0] imm_word;
   opcode_e         opc;
   logic [2:0]      funct3;
   logic            is_lui, is_jal, is_br, is_ld, is_st, is_alu;
   logic            f3_ok, alu_ok, is_slt, done_pass;
   logic            en, cnt_last, br_cond, wr;
   alu_op_e         alu_op;
   rd_src_e         rd_src;

   assign opc    = opcode_e'(ir[6:0]);
   assign funct3 = ir[F3_LSB +: 3];
   assign is_lui = (opc == LUI);
   assign is_jal = (opc == JAL);
   assign is_br  = (opc == BRANCH);
   assign is_ld  = (opc == LOAD);
   assign is_st  = (opc == STORE);
   assign is_alu = (opc == OP) || (opc == OP_IMM);

   always_comb begin
      case (opc)
         LUI:     imm_word = {ir[31:12], 12'b0};
         JAL:     imm_word = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
         BRANCH:  imm_word = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
         STORE:   imm_word = {{21{ir[31]}}, ir[30:25], ir[11:7]};
         default: imm_word = {{21{ir[31]}}, ir[30:20]};
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // operation select
   always_comb begin
      alu_op = ALU_ADD;
      f3_ok  = 1'b1;
      if (is_br) begin
         case (funct3)
            F3_BLT:  alu_op = ALU_SLT;
            F3_BLTU: alu_op = ALU_SLTU;
            default: alu_op = ALU_SUB;
         endcase
      end else if (is_alu) begin
         case (funct3)
            F3_ADD_SUB: alu_op = ((opc == OP) && ir[F7_SUB_BIT]) ? ALU_SUB : ALU_ADD;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
            default:    f3_ok  = 1'b0;  // shifts run as nop.
         endcase
      end
   end

   assign alu_ok    = is_alu && f3_ok;
   assign is_slt    = alu_ok && ((alu_op == ALU_SLT) || (alu_op == ALU_SLTU));
   assign done_pass = !is_slt || pass2;

   assign rd_src = is_lui ? RD_IMM : is_jal ? RD_PC4 : is_ld ? RD_MEM : RD_ALU;

   always_comb begin
      case (funct3)
         F3_BEQ:          br_cond = i_eq;
         F3_BNE:          br_cond = !i_eq;
         F3_BLT, F3_BLTU: br_cond = i_lt;
         default:         br_cond = 1'b0;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sequencing
   assign en       = (state == S_EXEC) || (state == S_WB);
   assign cnt_last = en && (cnt == 5'd31);

   always_comb begin
      state_nxt = state;
      case (state)
         S_FETCH:  if (i_ibus_ack) state_nxt = S_DECODE;
         S_DECODE: state_nxt = S_EXEC;
         S_EXEC: begin
            if (cnt_last && done_pass) begin
               state_nxt = (is_ld || is_st) ? S_MEM : S_FETCH;
            end
         end
         S_MEM:    if (i_dbus_ack) state_nxt = is_ld ? S_WB : S_FETCH;
         S_WB:     if (cnt_last) state_nxt = S_FETCH;
         default:  state_nxt = S_FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= S_FETCH;
         cnt   <= 5'd0;
         pass2 <= 1'b0;
      end else begin
         state <= state_nxt;
         if (en) cnt <= cnt + 5'd1;
         if ((state == S_EXEC) && cnt_last) pass2 <= is_slt && !pass2;
      end
   end

   always_ff @(posedge clk) begin
      if ((state == S_FETCH) && i_ibus_ack) ir <= i_ibus_rdt;
      if (state == S_DECODE) begin
         imm_sr <= imm_word;
      end else if (state == S_EXEC) begin
         imm_sr <= {imm_sr[0], imm_sr[XLEN-1:1]};  // rotate, slt reuses it.
      end
   end

   assign wr = (state == S_WB) ||
               ((state == S_EXEC) && (is_lui || is_jal || (alu_ok && done_pass)));

   always_comb begin
      o_ctrl.cnt    = cnt;
      o_ctrl.en     = en;
      o_ctrl.init   = en && (cnt == 5'd0);
      o_ctrl.last   = cnt_last;
      o_ctrl.alu_op = alu_op;
      o_ctrl.b_imm  = (opc == OP_IMM) || is_ld || is_st;
      o_ctrl.rd_src = rd_src;
      o_ctrl.rd_we  = wr;
      o_ctrl.rd     = ir[RD_LSB +: 5];
      o_ctrl.rs1    = ir[RS1_LSB +: 5];
      o_ctrl.rs2    = ir[RS2_LSB +: 5];
      o_ctrl.imm    = imm_sr[0];
   end

   assign o_fetch   = (state == S_FETCH) || (state_nxt == S_FETCH);
   assign o_mem_req = (state == S_MEM) || (state_nxt == S_MEM);
   assign o_mem_we  = is_st;
   assign o_pc_load = (state == S_EXEC) && cnt_last && done_pass;
   assign o_take    = is_jal || (is_br && br_cond);

endmodule

// File: src/rv_pc_ctrl.sv
`timescale 1ns/1ns

module rv_pc_ctrl import rv_isa_pkg::*, rv_bus_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  logic      clk,
   input  logic      i_arst_n,
   input  dp_ctrl_t  i_ctrl,
   input  logic      i_fetch,
   input  logic      i_ibus_ack,
   input  logic      i_pc_load,
   input  logic      i_take,
   output logic      o_pc4,
   output ibus_req_t o_ibus
);

   logic [XLEN-1:0] pc;
   logic [XLEN-2:0] pc4_sr;
   logic [XLEN-2:0] tgt_sr;
   logic            c4_q, ct_q;
   logic            ibus_cyc;
   logic            pc_bit, four_bit, c4, ct;
   logic            pc4_bit, tgt_bit;

   // two serial adders over the same pc bit.
   assign pc_bit   = pc[i_ctrl.cnt];
   assign four_bit = (i_ctrl.cnt == 5'd2);
   assign c4       = i_ctrl.init ? 1'b0 : c4_q;
   assign ct       = i_ctrl.init ? 1'b0 : ct_q;
   assign pc4_bit  = pc_bit ^ four_bit ^ c4;
   assign tgt_bit  = pc_bit ^ i_ctrl.imm ^ ct;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc       <= RESET_PC;
         c4_q     <= 1'b0;
         ct_q     <= 1'b0;
         ibus_cyc <= 1'b0;
      end else begin
         if (i_ctrl.en) begin
            c4_q <= (pc_bit & four_bit) | (c4 & (pc_bit ^ four_bit));
            ct_q <= (pc_bit & i_ctrl.imm) | (ct & (pc_bit ^ i_ctrl.imm));
         end
         if (i_pc_load) pc <= i_take ? {tgt_bit, tgt_sr} : {pc4_bit, pc4_sr};
         ibus_cyc <= i_fetch && !(ibus_cyc && i_ibus_ack);  // drop after ack.
      end
   end

   always_ff @(posedge clk) begin
      if (i_ctrl.en) begin
         pc4_sr <= {pc4_bit, pc4_sr[XLEN-2:1]};
         tgt_sr <= {tgt_bit, tgt_sr[XLEN-2:1]};
      end
   end

   assign o_pc4  = pc4_bit;
   assign o_ibus = '{adr: pc, cyc: ibus_cyc};

endmodule

// File: src/rv_alu.sv
`timescale 1ns/1ns

module rv_alu import rv_isa_pkg::*; (
   input  logic     clk,
   input  logic     i_arst_n,
   input  dp_ctrl_t i_ctrl,
   input  logic     i_rs1,
   input  logic     i_rs2,
   output logic     o_rd,
   output logic     o_eq,
   output logic     o_lt
);

   logic sub, b, c, sum, cout;
   logic eq_now, sgn_lt, is_cmp;
   logic carry_q, eq_q, flag_q;

   assign is_cmp = (i_ctrl.alu_op == ALU_SLT) || (i_ctrl.alu_op == ALU_SLTU);
   assign sub    = (i_ctrl.alu_op == ALU_SUB) || is_cmp;

   // a + ~b + 1 for subtract and compare.
   assign b    = i_rs2 ^ sub;
   assign c    = i_ctrl.init ? sub : carry_q;
   assign sum  = i_rs1 ^ b ^ c;
   assign cout = (i_rs1 & b) | (c & (i_rs1 ^ b));

   assign eq_now = (i_ctrl.init | eq_q) & ~(i_rs1 ^ i_rs2);

   // only meaningful on the last bit.
   assign sgn_lt = (i_rs1 ^ i_rs2) ? i_rs1 : ~cout;
   assign o_lt   = (i_ctrl.alu_op == ALU_SLTU) ? ~cout : sgn_lt;
   assign o_eq   = eq_now;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
         flag_q  <= 1'b0;
      end else if (i_ctrl.en) begin
         carry_q <= cout;
         eq_q    <= eq_now;
         if (i_ctrl.last && is_cmp) flag_q <= o_lt;  // kept for the second pass.
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND:            o_rd = i_rs1 & i_rs2;
         ALU_OR:             o_rd = i_rs1 | i_rs2;
         ALU_XOR:            o_rd = i_rs1 ^ i_rs2;
         ALU_SLT, ALU_SLTU:  o_rd = (i_ctrl.cnt == 5'd0) & flag_q;
         default:            o_rd = sum;
      endcase
   end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_isa_pkg::*; (
   input  logic     clk,
   input  logic     i_arst_n,
   input  dp_ctrl_t i_ctrl,
   input  logic     i_rd,
   output logic     o_rs1,
   output logic     o_rs2
);

   logic [XLEN-1:0] regs [1:31];
   logic [XLEN-2:0] wr_sr;
   logic            wr_en;

   // x0 is not stored.
   assign o_rs1 = (i_ctrl.rs1 == 5'd0) ? 1'b0 : regs[i_ctrl.rs1][i_ctrl.cnt];
   assign o_rs2 = (i_ctrl.rs2 == 5'd0) ? 1'b0 : regs[i_ctrl.rs2][i_ctrl.cnt];

   // collect the first 31 bits, the word lands with the last one.
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_sr <= '0;
      end else if (i_ctrl.en) begin
         wr_sr <= {i_rd, wr_sr[XLEN-2:1]};
      end
   end

   assign wr_en = i_ctrl.en && i_ctrl.last && i_ctrl.rd_we && (i_ctrl.rd != 5'd0);

   always_ff @(posedge clk) begin
      if (wr_en) regs[i_ctrl.rd] <= {i_rd, wr_sr};  // sources read old value.
   end

endmodule

// File: src/rv_mem_if.sv
`timescale 1ns/1ns

module rv_mem_if import rv_isa_pkg::*, rv_bus_pkg::*; (
   input  logic      clk,
   input  logic      i_arst_n,
   input  dp_ctrl_t  i_ctrl,
   input  logic      i_addr_bit,
   input  logic      i_rs2,
   input  logic      i_req,
   input  logic      i_we,
   output logic      o_rd,
   output dbus_req_t o_dbus,
   input  dbus_rsp_t i_dbus
);

   logic [XLEN-1:0] adr_sr;
   logic [XLEN-1:0] dat_sr;
   logic [XLEN-1:0] rdt_sr;
   logic            dbus_cyc;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         dbus_cyc <= 1'b0;
      end else begin
         dbus_cyc <= i_req && !(dbus_cyc && i_dbus.ack);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // serial to word and back
   always_ff @(posedge clk) begin
      if (i_ctrl.en) begin
         adr_sr <= {i_addr_bit, adr_sr[XLEN-1:1]};  // rs1 + imm from the alu.
         dat_sr <= {i_rs2, dat_sr[XLEN-1:1]};
      end
      if (dbus_cyc && i_dbus.ack) begin
         rdt_sr <= i_dbus.rdt;
      end else if (i_ctrl.en) begin
         rdt_sr <= {1'b0, rdt_sr[XLEN-1:1]};  // lsb first into rd.
      end
   end

   assign o_rd   = rdt_sr[0];
   assign o_dbus = '{adr: adr_sr, dat: dat_sr, we: i_we, cyc: dbus_cyc};

endmodule

// File: src/rv_serial_core.sv
`timescale 1ns/1ns

module rv_serial_core import rv_isa_pkg::*, rv_bus_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  logic      clk,
   input  logic      i_arst_n,
   output ibus_req_t o_ibus,
   input  ibus_rsp_t i_ibus,
   output dbus_req_t o_dbus,
   input  dbus_rsp_t i_dbus
);

   dp_ctrl_t ctrl;
   logic     fetch, mem_req, mem_we, pc_load, take;
   logic     eq, lt;
   logic     rs1, rs2, op_b;
   logic     alu_rd, pc4, mem_rd, rd_bit;

   rv_decode u_decode (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_ack (i_ibus.ack),
      .i_ibus_rdt (i_ibus.rdt),
      .i_dbus_ack (i_dbus.ack),
      .i_eq       (eq),
      .i_lt       (lt),
      .o_ctrl     (ctrl),
      .o_fetch    (fetch),
      .o_mem_req  (mem_req),
      .o_mem_we   (mem_we),
      .o_pc_load  (pc_load),
      .o_take     (take)
   );

   rv_pc_ctrl #(.RESET_PC(RESET_PC)) u_pc_ctrl (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ctrl     (ctrl),
      .i_fetch    (fetch),
      .i_ibus_ack (i_ibus.ack),
      .i_pc_load  (pc_load),
      .i_take     (take),
      .o_pc4      (pc4),
      .o_ibus     (o_ibus)
   );

   assign op_b = ctrl.b_imm ? ctrl.imm : rs2;

   rv_alu u_alu (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_ctrl   (ctrl),
      .i_rs1    (rs1),
      .i_rs2    (op_b),
      .o_rd     (alu_rd),
      .o_eq     (eq),
      .o_lt     (lt)
   );

   always_comb begin
      case (ctrl.rd_src)
         RD_PC4:  rd_bit = pc4;       // link address.
         RD_IMM:  rd_bit = ctrl.imm;
         RD_MEM:  rd_bit = mem_rd;
         default: rd_bit = alu_rd;
      endcase
   end

   rv_regfile u_regfile (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_ctrl   (ctrl),
      .i_rd     (rd_bit),
      .o_rs1    (rs1),
      .o_rs2    (rs2)
   );

   rv_mem_if u_mem_if (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ctrl     (ctrl),
      .i_addr_bit (alu_rd),
      .i_rs2      (rs2),
      .i_req      (mem_req),
      .i_we       (mem_we),
      .o_rd       (mem_rd),
      .o_dbus     (o_dbus),
      .i_dbus     (i_dbus)
   );

endmodule

// File: sim/rv_core_sva.sv
`timescale 1ns/1ns

module rv_core_sva import rv_bus_pkg::*; (
   input  logic      clk,
   input  logic      i_arst_n,
   input  ibus_req_t i_ibus_req,
   input  ibus_rsp_t i_ibus_rsp,
   input  dbus_req_t i_dbus_req,
   input  dbus_rsp_t i_dbus_rsp
);

   int unsigned fail_cnt = 0;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reset and bus exclusion
   a_reset_idle: assert property (
      @(posedge clk) !i_arst_n |-> !i_ibus_req.cyc && !i_dbus_req.cyc)
      else begin
         $error("bus cycle active while in reset.");
         fail_cnt++;
      end

   a_one_bus: assert property (
      @(posedge clk) disable iff (!i_arst_n) !(i_ibus_req.cyc && i_dbus_req.cyc))
      else begin
         $error("instruction and data bus cycles overlap.");
         fail_cnt++;
      end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // cyc/ack rule
   a_ibus_hold: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_ibus_req.cyc && !i_ibus_rsp.ack |=> i_ibus_req.cyc && $stable(i_ibus_req.adr))
      else begin
         $error("ibus request changed before ack.");
         fail_cnt++;
      end

   a_ibus_drop: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_ibus_req.cyc && i_ibus_rsp.ack |=> !i_ibus_req.cyc)
      else begin
         $error("ibus cyc still high after ack.");
         fail_cnt++;
      end

   a_dbus_hold: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_dbus_req.cyc && !i_dbus_rsp.ack |=> i_dbus_req.cyc && $stable(i_dbus_req.adr)
         && $stable(i_dbus_req.dat) && $stable(i_dbus_req.we))
      else begin
         $error("dbus request changed before ack.");
         fail_cnt++;
      end

   a_dbus_drop: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      i_dbus_req.cyc && i_dbus_rsp.ack |=> !i_dbus_req.cyc)
      else begin
         $error("dbus cyc still high after ack.");
         fail_cnt++;
      end

endmodule

bind rv_serial_core rv_core_sva u_sva (
   .clk        (clk),
   .i_arst_n   (i_arst_n),
   .i_ibus_req (o_ibus),
   .i_ibus_rsp (i_ibus),
   .i_dbus_req (o_dbus),
   .i_dbus_rsp (i_dbus)
);

// File: sim/tb_rv_serial_core.sv
`timescale 1ns/1ns

module tb_rv_serial_core import rv_isa_pkg::*, rv_bus_pkg::*; ();

   localparam logic [31:0] RESET_PC  = 32'h0000_0100;
   localparam logic [31:0] POISON    = 32'h0000_03fc;  // no legal store goes here.
   localparam int          RUN_LIMIT = 20000;

   logic        clk = 1'b0;
   logic        arst_n;
   ibus_req_t   ibus_req;
   ibus_rsp_t   ibus_rsp;
   dbus_req_t   dbus_req;
   dbus_rsp_t   dbus_rsp;

   integer      seed;
   logic [31:0] rnd;
   logic [31:0] prog [0:63];
   bit          no_fetch [0:63];
   logic [31:0] dmem [0:255];
   logic [31:0] rv [0:31];     // expected register contents.
   logic [63:0] exp_q [$];     // {address, data} per store.
   logic [31:0] st_adr;
   logic [31:0] end_adr;
   int          idx;
   int          end_hits;
   int          i_wait;
   int          d_wait;
   bit          i_busy;
   bit          d_busy;
   int          val_errs;
   int          run_errs;
   bit          timed_out;

   rv_serial_core #(.RESET_PC(RESET_PC)) DUT (
      .clk      (clk),
      .i_arst_n (arst_n),
      .o_ibus   (ibus_req),
      .i_ibus   (ibus_rsp),
      .o_dbus   (dbus_req),
      .i_dbus   (dbus_rsp)
   );

   always #20 clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference rules and encoders
   function automatic logic [31:0] fill_word(input logic [31:0] adr);
      return (adr * 32'h9e37_79b9) ^ 32'ha5a5_5a5a;
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
         F3_SLTU: return {31'b0, a < b};
         F3_XOR:  return a ^ b;
         F3_OR:   return a | b;
         F3_AND:  return a & b;
         default: return sub ? a - b : a + b;
      endcase
   endfunction

   function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
      case (f3)
         F3_BEQ:  return a == b;
         F3_BNE:  return a != b;
         F3_BLT:  return $signed(a) < $signed(b);
         default: return a < b;
      endcase
   endfunction

   function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [11:0] imm);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] r_type(input logic [2:0] f3, input logic sub,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP};
   endfunction

   function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
   endfunction

   function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
   endfunction

   function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
   endfunction

   function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, LUI};
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // program assembly
   task automatic emit_insn(input logic [31:0] insn);
      prog[idx] = insn;
      idx++;
   endtask

   task automatic emit_skipped(input logic [31:0] insn);
      no_fetch[idx] = 1'b1;
      emit_insn(insn);
   endtask

   task automatic store_reg(input logic [4:0] rs2);
      emit_insn(s_type(rs2, 5'd0, st_adr[11:0]));
      exp_q.push_back({st_adr, rv[rs2]});
      st_adr += 32'd4;
   endtask

   task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
      emit_insn(u_type(rd, imm));
      rv[rd] = {imm, 12'h000};
   endtask

   task automatic addi_op(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
      emit_insn(i_type(OP_IMM, rd, rs1, F3_ADD_SUB, imm));
      rv[rd] = rv[rs1] + sext12(imm);
   endtask

   task automatic reg_op(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
      emit_insn(r_type(f3, sub, rd, rs1, rs2));
      rv[rd] = alu_ref(f3, sub, rv[rs1], rv[rs2]);
      store_reg(rd);
   endtask

   // a taken branch jumps over the poison store and a fall-through stores x7.
   task automatic branch_op(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
      emit_insn(b_type(f3, rs1, rs2, 13'd8));
      if (branch_taken(f3, rv[rs1], rv[rs2])) begin
         emit_skipped(s_type(5'd7, 5'd0, POISON[11:0]));
      end else begin
         store_reg(5'd7);
      end
   endtask

   task automatic build_program();
      logic [31:0] w;
      logic [31:0] link;
      for (int a = 0; a < 64; a++) begin
         w           = fill_word(RESET_PC + 32'(4 * a));
         prog[a]     = {w[31:7], 7'b0001011};  // unsupported opcode runs as a nop.
         no_fetch[a] = 1'b0;
      end
      for (int a = 0; a < 256; a++) begin
         dmem[a] = fill_word(32'(4 * a));
      end
      idx    = 0;
      st_adr = 32'h0000_0200;
      rv[0]  = '0;
      rnd = $random(seed);
      load_upper(5'd3, {3'b101, rnd[16:0]});  // x1 negative.
      rnd = $random(seed);
      addi_op(5'd1, 5'd3, rnd[11:0]);
      rnd = $random(seed);
      load_upper(5'd4, {2'b01, rnd[17:0]});   // x2 positive.
      rnd = $random(seed);
      addi_op(5'd2, 5'd4, rnd[11:0]);
      rnd = $random(seed);
      addi_op(5'd7, 5'd0, rnd[11:0]);
      store_reg(5'd3);
      store_reg(5'd1);
      store_reg(5'd2);
      rnd = $random(seed);
      addi_op(5'd6, 5'd2, rnd[11:0]);
      store_reg(5'd6);
      reg_op(F3_ADD_SUB, 1'b0, 5'd5, 5'd1, 5'd2);
      reg_op(F3_ADD_SUB, 1'b1, 5'd5, 5'd1, 5'd2);
      reg_op(F3_AND, 1'b0, 5'd5, 5'd1, 5'd2);
      reg_op(F3_OR, 1'b0, 5'd5, 5'd1, 5'd2);
      reg_op(F3_XOR, 1'b0, 5'd5, 5'd1, 5'd2);
      reg_op(F3_SLT, 1'b0, 5'd5, 5'd1, 5'd2);
      reg_op(F3_SLTU, 1'b0, 5'd5, 5'd1, 5'd2);
      reg_op(F3_SLT, 1'b0, 5'd5, 5'd2, 5'd1);
      reg_op(F3_SLTU, 1'b0, 5'd5, 5'd2, 5'd1);
      emit_insn(32'h0000_000b);
      branch_op(F3_BEQ, 5'd1, 5'd1);
      branch_op(F3_BEQ, 5'd1, 5'd2);
      branch_op(F3_BNE, 5'd1, 5'd2);
      branch_op(F3_BNE, 5'd1, 5'd1);
      branch_op(F3_BLT, 5'd1, 5'd2);
      branch_op(F3_BLT, 5'd2, 5'd1);
      branch_op(F3_BLTU, 5'd2, 5'd1);
      branch_op(F3_BLTU, 5'd1, 5'd2);
      link = RESET_PC + 32'(4 * idx) + 32'd4;
      emit_insn(j_type(5'd8, 21'd12));         // jal over two stores.
      emit_skipped(s_type(5'd7, 5'd0, POISON[11:0]));
      emit_skipped(s_type(5'd7, 5'd0, POISON[11:0]));
      rv[8] = link;
      store_reg(5'd8);
      emit_insn(i_type(LOAD, 5'd9, 5'd0, 3'b010, 12'h300));
      rv[9] = fill_word(32'h0000_0300);
      store_reg(5'd9);
      end_adr = RESET_PC + 32'(4 * idx);
      emit_insn(j_type(5'd0, 21'd0));         // spin here.
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // memories that ack after 0 to 3 wait cycles
   always @(negedge clk) begin
      logic [63:0] want;
      logic [31:0] slot;
      if (ibus_rsp.ack) begin
         ibus_rsp.ack = 1'b0;
         i_busy       = 1'b0;
      end else if (ibus_req.cyc) begin
         if (!i_busy) begin
            i_busy = 1'b1;
            i_wait = $random(seed) & 3;
         end
         if (i_wait == 0) begin
            slot = (ibus_req.adr - RESET_PC) >> 2;
            assert (slot < 64 && !no_fetch[slot]) else begin
               $display("** Error @ %0t ns: fetch from %h, skipped or outside program",
                        $time, ibus_req.adr);
               val_errs++;
            end
            if (ibus_req.adr == end_adr) end_hits++;
            ibus_rsp.rdt = prog[slot[5:0]];
            ibus_rsp.ack = 1'b1;
         end else begin
            i_wait--;
         end
      end

      if (dbus_rsp.ack) begin
         dbus_rsp.ack = 1'b0;
         d_busy       = 1'b0;
      end else if (dbus_req.cyc) begin
         if (!d_busy) begin
            d_busy = 1'b1;
            d_wait = $random(seed) & 3;
         end
         if (d_wait == 0) begin
            dbus_rsp.ack = 1'b1;
            if (dbus_req.we) begin
               assert (exp_q.size() > 0) else begin
                  $display("Store to %h came after all expected stores.", dbus_req.adr);
                  run_errs++;
               end
               if (exp_q.size() > 0) begin
                  want = exp_q.pop_front();
                  assert (dbus_req.adr == want[63:32] && dbus_req.dat == want[31:0]) else begin
                     $display("** Error @ %0t ns: store %h to %h, expected %h to %h",
                              $time, dbus_req.dat, dbus_req.adr, want[31:0], want[63:32]);
                     val_errs++;
                  end
               end
               dmem[dbus_req.adr[9:2]] = dbus_req.dat;
            end else begin
               dbus_rsp.rdt = dmem[dbus_req.adr[9:2]];
            end
         end else begin
            d_wait--;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // run sequence
   initial begin
      int n;
      seed      = 32'ha06b_25fb;
      arst_n    = 1'b0;
      ibus_rsp  = '0;
      dbus_rsp  = '0;
      i_busy    = 1'b0;
      d_busy    = 1'b0;
      i_wait    = 0;
      d_wait    = 0;
      end_hits  = 0;
      val_errs  = 0;
      run_errs  = 0;
      timed_out = 1'b0;
      build_program();
      repeat (5) begin
         @(negedge clk);
         assert (!ibus_req.cyc && !dbus_req.cyc) else begin
            $display("A bus cycle was active while reset was asserted.");
            run_errs++;
         end
      end
      arst_n = 1'b1;
      n = 0;
      while (!ibus_req.cyc && n < 4) begin
         @(negedge clk);
         n++;
      end
      if (!ibus_req.cyc) begin
         $display("Timeout: no instruction fetch started after reset release.");
         timed_out = 1'b1;
      end else begin
         assert (ibus_req.adr == RESET_PC) else begin
            $display("** Error @ %0t ns: first fetch from %h, expected %h",
                     $time, ibus_req.adr, RESET_PC);
            val_errs++;
         end
         n = 0;
         while (end_hits < 2 && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
         end
         if (end_hits < 2) begin
            $display("Timeout: the program never reached its final jump.");
            timed_out = 1'b1;
         end
      end
      assert (exp_q.size() == 0) else begin
         $display("%0d expected stores never appeared on the data bus.", exp_q.size());
         run_errs++;
      end
      $display("Errors: %0d wrong values, %0d other failures, %0d assertion failures",
               val_errs, run_errs, DUT.u_sva.fail_cnt);
      if (!timed_out && val_errs == 0 && run_errs == 0 && DUT.u_sva.fail_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: list.f
src/rv_isa_pkg.sv
src/rv_bus_pkg.sv
src/rv_decode.sv
src/rv_pc_ctrl.sv
src/rv_alu.sv
src/rv_regfile.sv
src/rv_mem_if.sv
src/rv_serial_core.sv
sim/rv_core_sva.sv
sim/tb_rv_serial_core.sv
